//--- Makefile
SIM = obj_dir/Vcore_io_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module core_io_tb

run: compile
	@out="$$(./$(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf obj_dir

//--- source/core_bus_pkg.sv
`default_nettype none

`include "core_io_macros.svh"

package core_bus_pkg;

  // Byte address on the core data bus
  typedef logic [`CIO_ADDR_WIDTH-1:0] addr_t;
  typedef logic [31:0]                word_t;
  typedef logic [3:0]                 strb_t;

  // 0 byte, 1 half, 2 word
  typedef logic [1:0]                 size_t;

endpackage

`default_nettype wire

//--- source/core_io_macros.svh
`ifndef CORE_IO_MACROS_SVH
`define CORE_IO_MACROS_SVH

// Core data bus address width and I/O window decode on the top two bits
`define CIO_ADDR_WIDTH  16
`define CIO_IO_WINDOW   2'b10
`define CIO_OFS_WIDTH   7

// Write register byte offsets inside the I/O window
`define CIO_SEND_DESC   7'h00
`define CIO_DRAM_ADDR   7'h08
`define CIO_SLOT_INFO   7'h10
`define CIO_TIMER_STEP  7'h14
`define CIO_DRAM_FLAGS  7'h18

// Single-byte strobe locations
`define CIO_SEND_STRB   7'h38
`define CIO_TAKEN_STRB  7'h39
`define CIO_FLAG_CLR    7'h3A
`define CIO_SLOT_STRB   7'h3B
`define CIO_MASK_WR     7'h3C
`define CIO_IRQ_ACK     7'h3D

// Read registers
`define CIO_RD_DESC     7'h40
`define CIO_RD_FLAGS    7'h48
`define CIO_RD_STAT     7'h4C
`define CIO_RD_ID       7'h50
`define CIO_RD_TIMER_L  7'h54
`define CIO_RD_TIMER_H  7'h58
`define CIO_RD_INT      7'h5C

// Only the external interrupt is enabled out of reset
`define CIO_MASK_RST    4'b0001
`define CIO_STEP_RST    32'd1

`endif

//--- source/core_io_pkg.sv
`default_nettype none

package core_io_pkg;

  typedef logic [63:0] desc_t;
  typedef logic [4:0]  tag_t;
  typedef logic [31:0] flags_t;

  // Bit 0 external, 1 timer, 2 DRAM receive, 3 incoming descriptor
  typedef logic [3:0]  irq_mask_t;

  typedef logic [3:0]  core_id_t;
  typedef logic [3:0]  slot_ptr_t;

endpackage

`default_nettype wire

//--- source/core_io_top.sv
`default_nettype none

module core_io_top (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     init_rst,
  input  core_io_pkg::core_id_t   core_id,

  input  wire                     dbus_cmd_valid,
  input  wire                     dbus_cmd_wr,
  input  core_bus_pkg::addr_t     dbus_cmd_addr,
  input  core_bus_pkg::word_t     dbus_cmd_data,
  input  core_bus_pkg::size_t     dbus_cmd_size,
  output logic                    dbus_rsp_ready,
  output core_bus_pkg::word_t     dbus_rsp_data,

  output logic                    ext_dmem_en,
  output logic                    ext_dmem_wen,
  output core_bus_pkg::strb_t     ext_dmem_strb,
  output core_bus_pkg::addr_t     ext_dmem_addr,
  output core_bus_pkg::word_t     ext_dmem_wr_data,
  input  core_bus_pkg::word_t     ext_dmem_rd_data,
  input  wire                     ext_dmem_rd_valid,

  input  core_io_pkg::desc_t      in_desc,
  input  wire                     in_desc_valid,
  output logic                    in_desc_taken,

  input  core_io_pkg::tag_t       recv_dram_tag,
  input  wire                     recv_dram_tag_valid,

  output core_io_pkg::desc_t      data_desc,
  output logic                    data_desc_valid,
  output core_io_pkg::desc_t      dram_wr_addr,
  input  wire                     data_desc_ready,

  output core_io_pkg::slot_ptr_t  slot_wr_ptr,
  output core_bus_pkg::addr_t     slot_wr_addr,
  output logic                    slot_wr_valid,
  output logic                    slot_for_hdr,
  input  wire                     slot_wr_ready,

  input  wire                     interrupt_in,
  output logic                    interrupt_in_ack,
  output logic                    timer_irq,
  output logic                    external_irq
);

  core_bus_pkg::word_t io_rdata;
  core_io_pkg::flags_t flags;
  logic [7:0]          int_flags;

  io_bus_if io_bus ();

  dbus_router u_router (
    .clk               (clk),
    .rst               (rst),
    .dbus_cmd_valid    (dbus_cmd_valid),
    .dbus_cmd_wr       (dbus_cmd_wr),
    .dbus_cmd_addr     (dbus_cmd_addr),
    .dbus_cmd_data     (dbus_cmd_data),
    .dbus_cmd_size     (dbus_cmd_size),
    .dbus_rsp_ready    (dbus_rsp_ready),
    .dbus_rsp_data     (dbus_rsp_data),
    .ext_dmem_en       (ext_dmem_en),
    .ext_dmem_wen      (ext_dmem_wen),
    .ext_dmem_strb     (ext_dmem_strb),
    .ext_dmem_addr     (ext_dmem_addr),
    .ext_dmem_wr_data  (ext_dmem_wr_data),
    .ext_dmem_rd_data  (ext_dmem_rd_data),
    .ext_dmem_rd_valid (ext_dmem_rd_valid),
    .io_rdata          (io_rdata),
    .io                (io_bus.router)
  );

  io_write_regs u_write_regs (
    .clk             (clk),
    .rst             (rst),
    .io              (io_bus.regs),
    .data_desc_ready (data_desc_ready),
    .data_desc       (data_desc),
    .data_desc_valid (data_desc_valid),
    .dram_wr_addr    (dram_wr_addr),
    .slot_wr_ptr     (slot_wr_ptr),
    .slot_wr_addr    (slot_wr_addr),
    .slot_wr_valid   (slot_wr_valid),
    .slot_for_hdr    (slot_for_hdr),
    .in_desc_taken   (in_desc_taken)
  );

  io_read_regs u_read_regs (
    .clk             (clk),
    .init_rst        (init_rst),
    .io              (io_bus.regs),
    .in_desc         (in_desc),
    .in_desc_valid   (in_desc_valid),
    .core_id         (core_id),
    .data_desc_ready (data_desc_ready),
    .slot_wr_ready   (slot_wr_ready),
    .flags           (flags),
    .int_flags       (int_flags),
    .io_rdata        (io_rdata)
  );

  irq_ctrl u_irq (
    .clk                 (clk),
    .rst                 (rst),
    .io                  (io_bus.irq),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .interrupt_in        (interrupt_in),
    .in_desc_valid       (in_desc_valid),
    .flags               (flags),
    .int_flags           (int_flags),
    .timer_irq           (timer_irq),
    .external_irq        (external_irq),
    .interrupt_in_ack    (interrupt_in_ack)
  );

endmodule

`default_nettype wire

//--- source/dbus_router.sv
`default_nettype none

`include "core_io_macros.svh"

module dbus_router (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 dbus_cmd_valid,
  input  wire                 dbus_cmd_wr,
  input  core_bus_pkg::addr_t dbus_cmd_addr,
  input  core_bus_pkg::word_t dbus_cmd_data,
  input  core_bus_pkg::size_t dbus_cmd_size,
  output logic                dbus_rsp_ready,
  output core_bus_pkg::word_t dbus_rsp_data,
  output logic                ext_dmem_en,
  output logic                ext_dmem_wen,
  output core_bus_pkg::strb_t ext_dmem_strb,
  output core_bus_pkg::addr_t ext_dmem_addr,
  output core_bus_pkg::word_t ext_dmem_wr_data,
  input  core_bus_pkg::word_t ext_dmem_rd_data,
  input  wire                 ext_dmem_rd_valid,
  input  core_bus_pkg::word_t io_rdata,
  io_bus_if.router            io
);

  core_bus_pkg::strb_t size_strb;
  core_bus_pkg::strb_t cmd_strb;
  logic                io_win;
  logic                io_rsp_r;

  assign io_win = dbus_cmd_addr[`CIO_ADDR_WIDTH-1 -: 2] == `CIO_IO_WINDOW;

  // Access size and low address bits to byte enables
  always_comb begin
    case (dbus_cmd_size)
      2'd0:    size_strb = 4'b0001 << dbus_cmd_addr[1:0];
      2'd1:    size_strb = 4'b0011 << dbus_cmd_addr[1:0];
      default: size_strb = 4'b1111;
    endcase
  end

  // No byte enables on reads
  assign cmd_strb = (dbus_cmd_valid && dbus_cmd_wr) ? size_strb : 4'b0000;

  assign ext_dmem_en      = dbus_cmd_valid && !io_win;
  assign ext_dmem_wen     = dbus_cmd_wr;
  assign ext_dmem_strb    = cmd_strb;
  assign ext_dmem_addr    = dbus_cmd_addr;
  assign ext_dmem_wr_data = dbus_cmd_data;

  assign io.wr    = dbus_cmd_valid && io_win && dbus_cmd_wr;
  assign io.rd    = dbus_cmd_valid && io_win && !dbus_cmd_wr;
  assign io.ofs   = dbus_cmd_addr[`CIO_OFS_WIDTH-1:0];
  assign io.wdata = {dbus_cmd_data, dbus_cmd_data};
  // Address bit 2 moves the strobe into the upper half
  assign io.lanes = {4'b0000, cmd_strb} << {dbus_cmd_addr[2], 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rsp_r <= 1'b0;
    end else begin
      io_rsp_r <= io.rd;
    end
  end

  assign dbus_rsp_ready = ext_dmem_rd_valid || io_rsp_r;
  assign dbus_rsp_data  = io_rsp_r ? io_rdata : ext_dmem_rd_data;

endmodule

`default_nettype wire

//--- source/io_bus_if.sv
`default_nettype none

`include "core_io_macros.svh"

interface io_bus_if;

  logic                      wr;
  logic                      rd;
  logic [`CIO_OFS_WIDTH-1:0] ofs;
  // Write word in both halves with lanes marking the live bytes
  logic [63:0]               wdata;
  logic [7:0]                lanes;

  modport router (output wr, rd, ofs, wdata, lanes);
  modport regs   (input wr, rd, ofs, wdata, lanes);
  modport irq    (input wr, ofs, wdata, lanes);

endinterface

`default_nettype wire

//--- source/io_read_regs.sv
`default_nettype none

`include "core_io_macros.svh"

module io_read_regs (
  input  wire                    clk,
  input  wire                    init_rst,
  io_bus_if.regs                 io,
  input  core_io_pkg::desc_t     in_desc,
  input  wire                    in_desc_valid,
  input  core_io_pkg::core_id_t  core_id,
  input  wire                    data_desc_ready,
  input  wire                    slot_wr_ready,
  input  core_io_pkg::flags_t    flags,
  input  wire [7:0]              int_flags,
  output core_bus_pkg::word_t    io_rdata
);

  logic [63:0]                   timer_r;
  logic [`CIO_OFS_WIDTH-1:0]     word_ofs;
  core_bus_pkg::word_t           rd_word;
  core_bus_pkg::word_t           rdata_r;

  // Free-running cycle counter that only power-up init clears
  always_ff @(posedge clk) begin
    if (init_rst) begin
      timer_r <= 64'd0;
    end else begin
      timer_r <= timer_r + 64'd1;
    end
  end

  assign word_ofs = {io.ofs[6:2], 2'b00};

  always_comb begin
    case (word_ofs)
      `CIO_RD_DESC, `CIO_RD_DESC + 7'h4:
        rd_word = io.ofs[2] ? in_desc[63:32] : in_desc[31:0];
      `CIO_RD_FLAGS:   rd_word = flags;
      `CIO_RD_STAT:
        rd_word = {8'd0, 7'd0, slot_wr_ready, 7'd0, data_desc_ready,
                   7'd0, in_desc_valid};
      `CIO_RD_ID:      rd_word = {28'd0, core_id};
      `CIO_RD_TIMER_L: rd_word = timer_r[31:0];
      `CIO_RD_TIMER_H: rd_word = timer_r[63:32];
      `CIO_RD_INT:     rd_word = {24'd0, int_flags};
      default:         rd_word = 32'd0;
    endcase
  end

  // Response word comes back the cycle after the read
  always_ff @(posedge clk) begin
    if (io.rd) begin
      rdata_r <= rd_word;
    end
  end

  assign io_rdata = rdata_r;

endmodule

`default_nettype wire

//--- source/io_write_regs.sv
`default_nettype none

`include "core_io_macros.svh"

module io_write_regs (
  input  wire                     clk,
  input  wire                     rst,
  io_bus_if.regs                  io,
  input  wire                     data_desc_ready,
  output core_io_pkg::desc_t      data_desc,
  output logic                    data_desc_valid,
  output core_io_pkg::desc_t      dram_wr_addr,
  output core_io_pkg::slot_ptr_t  slot_wr_ptr,
  output core_bus_pkg::addr_t     slot_wr_addr,
  output logic                    slot_wr_valid,
  output logic                    slot_for_hdr,
  output logic                    in_desc_taken
);

  core_io_pkg::desc_t desc_r;
  core_io_pkg::desc_t dram_addr_r;
  logic [31:0]        slot_info_r;
  logic               desc_valid_r;

  logic desc_wen;
  logic dram_addr_wen;
  logic slot_info_wen;
  logic send_hit;
  logic taken_hit;
  logic slot_hit;
  logic strb_set;

  //////////////////////////////////////////////////////////////////////
  // Offset decode

  assign desc_wen      = io.wr && ({io.ofs[6:3], 3'b000} == `CIO_SEND_DESC);
  assign dram_addr_wen = io.wr && ({io.ofs[6:3], 3'b000} == `CIO_DRAM_ADDR);
  assign slot_info_wen = io.wr && ({io.ofs[6:2], 2'b00} == `CIO_SLOT_INFO);

  assign send_hit  = io.wr && (io.ofs == `CIO_SEND_STRB);
  assign taken_hit = io.wr && (io.ofs == `CIO_TAKEN_STRB);
  assign slot_hit  = io.wr && (io.ofs == `CIO_SLOT_STRB);

  // Byte data is replicated, so bit 0 is valid for any byte address
  assign strb_set = io.wdata[0];

  //////////////////////////////////////////////////////////////////////
  // Byte-writable registers

  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      if (desc_wen && io.lanes[i]) begin
        desc_r[i*8 +: 8] <= io.wdata[i*8 +: 8];
      end
      if (dram_addr_wen && io.lanes[i]) begin
        dram_addr_r[i*8 +: 8] <= io.wdata[i*8 +: 8];
      end
    end
    // Slot info sits in the lower word
    for (int i = 0; i < 4; i++) begin
      if (slot_info_wen && io.lanes[i]) begin
        slot_info_r[i*8 +: 8] <= io.wdata[i*8 +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Descriptor valid holds until the consumer takes it

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid_r <= 1'b0;
    end else begin
      if (send_hit && strb_set) begin
        desc_valid_r <= 1'b1;
      end
      if (desc_valid_r && data_desc_ready) begin
        desc_valid_r <= 1'b0;
      end
    end
  end

  assign data_desc       = desc_r;
  assign data_desc_valid = desc_valid_r;
  assign dram_wr_addr    = dram_addr_r;

  assign slot_wr_addr  = slot_info_r[15:0];
  assign slot_wr_ptr   = slot_info_r[27:24];
  assign slot_for_hdr  = slot_info_r[31];
  assign slot_wr_valid = slot_hit && strb_set;
  assign in_desc_taken = taken_hit && strb_set;

endmodule

`default_nettype wire

//--- source/irq_ctrl.sv
`default_nettype none

`include "core_io_macros.svh"

module irq_ctrl (
  input  wire                  clk,
  input  wire                  rst,
  io_bus_if.irq                io,
  input  core_io_pkg::tag_t    recv_dram_tag,
  input  wire                  recv_dram_tag_valid,
  input  wire                  interrupt_in,
  input  wire                  in_desc_valid,
  output core_io_pkg::flags_t  flags,
  output logic [7:0]           int_flags,
  output logic                 timer_irq,
  output logic                 external_irq,
  output logic                 interrupt_in_ack
);

  core_io_pkg::irq_mask_t mask_r;
  logic [31:0]            step_r;
  logic [31:0]            count_r;
  logic                   timer_pend_r;
  logic                   ack_r;
  core_io_pkg::tag_t      tag_r;
  logic                   tag_valid_r;
  core_io_pkg::flags_t    flags_r;
  logic                   flag_any;

  logic mask_wen;
  logic step_wen;
  logic flags_wen;
  logic clr_wen;
  logic ack_wen;

  assign mask_wen  = io.wr && (io.ofs == `CIO_MASK_WR) && io.lanes[4];
  assign step_wen  = io.wr && ({io.ofs[6:2], 2'b00} == `CIO_TIMER_STEP);
  assign flags_wen = io.wr && ({io.ofs[6:2], 2'b00} == `CIO_DRAM_FLAGS);
  assign clr_wen   = io.wr && (io.ofs == `CIO_FLAG_CLR);
  assign ack_wen   = io.wr && (io.ofs == `CIO_IRQ_ACK);

  //////////////////////////////////////////////////////////////////////
  // Mask and timer interrupt

  always_ff @(posedge clk) begin
    if (rst) begin
      mask_r <= `CIO_MASK_RST;
      step_r <= `CIO_STEP_RST;
    end else begin
      if (mask_wen) begin
        mask_r <= io.wdata[35:32];
      end
      // Step lives at a word offset with bit 2 set, so upper lanes
      for (int i = 4; i < 8; i++) begin
        if (step_wen && io.lanes[i]) begin
          step_r[(i-4)*8 +: 8] <= io.wdata[i*8 +: 8];
        end
      end
    end
  end

  // A step write restarts the period
  always_ff @(posedge clk) begin
    if (rst || step_wen) begin
      count_r      <= 32'd0;
      timer_pend_r <= 1'b0;
    end else if (count_r == step_r) begin
      count_r      <= 32'd0;
      timer_pend_r <= 1'b1;
    end else begin
      count_r <= count_r + 32'd1;
      if (ack_wen && io.wdata[13]) begin
        timer_pend_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_r <= 1'b0;
    end else begin
      ack_r <= ack_wen && io.wdata[12];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // DRAM receive flags

  always_ff @(posedge clk) begin
    tag_r <= recv_dram_tag;
    if (rst) begin
      tag_valid_r <= 1'b0;
    end else begin
      tag_valid_r <= recv_dram_tag_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_r <= 32'd0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (flags_wen && io.lanes[i]) begin
          flags_r[i*8 +: 8] <= io.wdata[i*8 +: 8];
        end
      end
      if (clr_wen) begin
        flags_r[io.wdata[20:16]] <= 1'b0;
      end
      // Arriving tag wins over a clear of the same bit
      if (tag_valid_r) begin
        flags_r[tag_r] <= 1'b1;
      end
      flags_r[0] <= 1'b0;
    end
  end

  assign flag_any = |flags_r;

  assign flags            = flags_r;
  assign int_flags        = {mask_r, in_desc_valid, flag_any, timer_pend_r, interrupt_in};
  assign timer_irq        = timer_pend_r && mask_r[1];
  assign external_irq     = (interrupt_in && mask_r[0]) ||
                            (flag_any && mask_r[2]) ||
                            (in_desc_valid && mask_r[3]);
  assign interrupt_in_ack = ack_r;

endmodule

`default_nettype wire

//--- test/core_io_asserts.sv
`default_nettype none

`include "core_io_macros.svh"

module core_io_asserts (
  input wire                 clk,
  input wire                 rst,
  input wire                 dbus_cmd_valid,
  input wire                 dbus_cmd_wr,
  input core_bus_pkg::addr_t dbus_cmd_addr,
  input wire                 dbus_rsp_ready,
  input wire                 data_desc_valid,
  input wire                 data_desc_ready,
  input wire                 slot_wr_valid
);

  int   slot_fails = 0;
  int   hold_fails = 0;
  int   rsp_fails  = 0;
  logic io_read;

  assign io_read = dbus_cmd_valid && !dbus_cmd_wr &&
                   (dbus_cmd_addr[`CIO_ADDR_WIDTH-1 -: 2] == `CIO_IO_WINDOW);

  slot_pulse: assert property (@(posedge clk) disable iff (rst)
      slot_wr_valid |=> !slot_wr_valid)
    else begin
      slot_fails++;
      $error("slot_wr_valid stayed high for more than one cycle");
    end

  // Descriptor valid holds until the consumer is ready
  desc_hold: assert property (@(posedge clk) disable iff (rst)
      data_desc_valid && !data_desc_ready |=> data_desc_valid)
    else begin
      hold_fails++;
      $error("data_desc_valid dropped without data_desc_ready");
    end

  io_rsp: assert property (@(posedge clk) disable iff (rst)
      io_read |=> dbus_rsp_ready)
    else begin
      rsp_fails++;
      $error("dbus_rsp_ready missing one cycle after an I/O read");
    end

endmodule

bind core_io_top core_io_asserts u_asserts (
  .clk             (clk),
  .rst             (rst),
  .dbus_cmd_valid  (dbus_cmd_valid),
  .dbus_cmd_wr     (dbus_cmd_wr),
  .dbus_cmd_addr   (dbus_cmd_addr),
  .dbus_rsp_ready  (dbus_rsp_ready),
  .data_desc_valid (data_desc_valid),
  .data_desc_ready (data_desc_ready),
  .slot_wr_valid   (slot_wr_valid)
);

`default_nettype wire

//--- test/core_io_tb.sv
`default_nettype none

`include "core_io_macros.svh"

module core_io_tb;

  // The directed tests run for about 100 cycles
  localparam int max_cycles = 3000;

  logic                    clk;
  logic                    rst;
  logic                    init_rst;
  core_io_pkg::core_id_t   core_id;
  logic                    dbus_cmd_valid;
  logic                    dbus_cmd_wr;
  core_bus_pkg::addr_t     dbus_cmd_addr;
  core_bus_pkg::word_t     dbus_cmd_data;
  core_bus_pkg::size_t     dbus_cmd_size;
  logic                    dbus_rsp_ready;
  core_bus_pkg::word_t     dbus_rsp_data;
  logic                    ext_dmem_en;
  logic                    ext_dmem_wen;
  core_bus_pkg::strb_t     ext_dmem_strb;
  core_bus_pkg::addr_t     ext_dmem_addr;
  core_bus_pkg::word_t     ext_dmem_wr_data;
  core_bus_pkg::word_t     ext_dmem_rd_data = '0;
  logic                    ext_dmem_rd_valid = 1'b0;
  core_io_pkg::desc_t      in_desc;
  logic                    in_desc_valid;
  logic                    in_desc_taken;
  core_io_pkg::tag_t       recv_dram_tag;
  logic                    recv_dram_tag_valid;
  core_io_pkg::desc_t      data_desc;
  logic                    data_desc_valid;
  core_io_pkg::desc_t      dram_wr_addr;
  logic                    data_desc_ready;
  core_io_pkg::slot_ptr_t  slot_wr_ptr;
  core_bus_pkg::addr_t     slot_wr_addr;
  logic                    slot_wr_valid;
  logic                    slot_for_hdr;
  logic                    slot_wr_ready;
  logic                    interrupt_in;
  logic                    interrupt_in_ack;
  logic                    timer_irq;
  logic                    external_irq;

  core_bus_pkg::word_t     mem [0:255];
  int                      errors = 0;
  int                      cycles = 0;

  core_io_top dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Data memory model that returns a read word one cycle after the request
  always @(posedge clk) begin
    ext_dmem_rd_valid <= 1'b0;
    if (ext_dmem_en && ext_dmem_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (ext_dmem_strb[b]) begin
          mem[ext_dmem_addr[9:2]][b*8 +: 8] <= ext_dmem_wr_data[b*8 +: 8];
        end
      end
    end else if (ext_dmem_en) begin
      ext_dmem_rd_data  <= mem[ext_dmem_addr[9:2]];
      ext_dmem_rd_valid <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
      finish_run(1'b1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus helpers

  function automatic core_bus_pkg::addr_t io_addr(input logic [`CIO_OFS_WIDTH-1:0] ofs);
    io_addr = {`CIO_IO_WINDOW, 7'd0, ofs};
  endfunction

  task automatic step_cycle;
    @(posedge clk);
    #10;
  endtask

  task automatic idle_cmd;
    dbus_cmd_valid = 1'b0;
    dbus_cmd_wr    = 1'b0;
    dbus_cmd_addr  = '0;
    dbus_cmd_data  = '0;
    dbus_cmd_size  = '0;
  endtask

  task automatic drive_cmd(input logic wr, input core_bus_pkg::addr_t addr,
                           input core_bus_pkg::word_t data, input core_bus_pkg::size_t size);
    dbus_cmd_valid = 1'b1;
    dbus_cmd_wr    = wr;
    dbus_cmd_addr  = addr;
    dbus_cmd_data  = data;
    dbus_cmd_size  = size;
  endtask

  task automatic finish_cmd;
    step_cycle();
    idle_cmd();
  endtask

  task automatic bus_write(input core_bus_pkg::addr_t addr, input core_bus_pkg::word_t data,
                           input core_bus_pkg::size_t size);
    drive_cmd(1'b1, addr, data, size);
    finish_cmd();
  endtask

  task automatic bus_read(input core_bus_pkg::addr_t addr, output core_bus_pkg::word_t data);
    int waited;
    drive_cmd(1'b0, addr, 32'd0, 2'd2);
    finish_cmd();
    waited = 0;
    @(negedge clk);
    while (!dbus_rsp_ready && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    if (!dbus_rsp_ready) begin
      errors++;
      $display("No response on the data bus for the read of address %h", addr);
    end
    data = dbus_rsp_data;
    step_cycle();
  endtask

  task automatic check(input string test, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", test, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic mem_write_check(input core_bus_pkg::addr_t addr, input core_bus_pkg::word_t data,
                                 input core_bus_pkg::size_t size, input core_bus_pkg::strb_t strb);
    drive_cmd(1'b1, addr, data, size);
    @(negedge clk);
    check("mem_routing enable", 64'd1, 64'(ext_dmem_en && ext_dmem_wen));
    check("mem_routing strobe", 64'(strb), 64'(ext_dmem_strb));
    check("mem_routing address", 64'(addr), 64'(ext_dmem_addr));
    check("mem_routing data", 64'(data), 64'(ext_dmem_wr_data));
    finish_cmd();
  endtask

  task automatic route_mem_accesses;
    core_bus_pkg::word_t w;
    core_bus_pkg::word_t rd;
    w = $urandom;
    mem_write_check(16'h0200, w, 2'd2, 4'b1111);
    mem_write_check(16'h0202, 32'h1234_0000, 2'd1, 4'b1100);
    mem_write_check(16'h0201, 32'h0000_5a00, 2'd0, 4'b0010);
    // Reads carry no strobes and I/O accesses leave the memory port idle
    drive_cmd(1'b0, 16'h0200, 32'd0, 2'd2);
    @(negedge clk);
    check("mem_routing read enable", 64'd1, 64'(ext_dmem_en));
    check("mem_routing read strobe", 64'd0, 64'(ext_dmem_strb));
    finish_cmd();
    drive_cmd(1'b0, io_addr(`CIO_RD_ID), 32'd0, 2'd2);
    @(negedge clk);
    check("mem_routing io access", 64'd0, 64'(ext_dmem_en));
    finish_cmd();
    bus_read(16'h0200, rd);
    check("mem_routing read", 64'({16'h1234, 8'h5a, w[7:0]}), 64'(rd));
  endtask

  task automatic send_descriptor;
    core_io_pkg::desc_t desc;
    core_io_pkg::desc_t addr;
    desc = {$urandom, $urandom};
    addr = {$urandom, $urandom};
    bus_write(io_addr(`CIO_SEND_DESC), desc[31:0], 2'd2);
    bus_write(io_addr(`CIO_SEND_DESC + 7'h4), desc[63:32], 2'd2);
    bus_write(io_addr(`CIO_DRAM_ADDR), addr[31:0], 2'd2);
    bus_write(io_addr(`CIO_DRAM_ADDR + 7'h4), addr[63:32], 2'd2);
    @(negedge clk);
    check("desc_send data_desc", desc, data_desc);
    check("desc_send dram_wr_addr", addr, dram_wr_addr);
    check("desc_send valid before strobe", 64'd0, 64'(data_desc_valid));
    step_cycle();
    bus_write(io_addr(`CIO_SEND_STRB), 32'h0101_0101, 2'd0);
    // Rise plus three held cycles with ready low
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check("desc_send valid held", 64'd1, 64'(data_desc_valid));
      step_cycle();
    end
    data_desc_ready = 1'b1;
    step_cycle();
    data_desc_ready = 1'b0;
    @(negedge clk);
    check("desc_send valid dropped", 64'd0, 64'(data_desc_valid));
    step_cycle();
  endtask

  task automatic read_io_registers;
    core_io_pkg::desc_t  desc;
    core_bus_pkg::word_t rd;
    core_bus_pkg::word_t t0;
    desc = {$urandom, $urandom};
    in_desc = desc;
    bus_read(io_addr(`CIO_RD_DESC), rd);
    check("reads desc low", 64'(desc[31:0]), 64'(rd));
    bus_read(io_addr(`CIO_RD_DESC + 7'h4), rd);
    check("reads desc high", 64'(desc[63:32]), 64'(rd));
    bus_read(io_addr(`CIO_RD_ID), rd);
    check("reads core id", 64'h6, 64'(rd));
    // Status bytes hold in_desc_valid, data_desc_ready and slot_wr_ready
    in_desc_valid = 1'b1;
    slot_wr_ready = 1'b1;
    bus_read(io_addr(`CIO_RD_STAT), rd);
    check("reads status a", 64'h0001_0001, 64'(rd));
    in_desc_valid   = 1'b0;
    slot_wr_ready   = 1'b0;
    data_desc_ready = 1'b1;
    bus_read(io_addr(`CIO_RD_STAT), rd);
    check("reads status b", 64'h0000_0100, 64'(rd));
    data_desc_ready = 1'b0;
    bus_read(io_addr(`CIO_RD_TIMER_L), t0);
    bus_read(io_addr(`CIO_RD_TIMER_L), rd);
    check("reads timer increases", 64'd1, 64'(rd > t0));
    drive_cmd(1'b1, io_addr(`CIO_TAKEN_STRB), 32'h0101_0101, 2'd0);
    @(negedge clk);
    check("reads taken strobe", 64'd1, 64'(in_desc_taken));
    finish_cmd();
    @(negedge clk);
    check("reads taken idle", 64'd0, 64'(in_desc_taken));
    step_cycle();
  endtask

  task automatic write_slot_info;
    core_bus_pkg::word_t info;
    info = $urandom;
    bus_write(io_addr(`CIO_SLOT_INFO), info, 2'd2);
    drive_cmd(1'b1, io_addr(`CIO_SLOT_STRB), 32'h0101_0101, 2'd0);
    @(negedge clk);
    check("slot_write valid", 64'd1, 64'(slot_wr_valid));
    check("slot_write pointer", 64'(info[27:24]), 64'(slot_wr_ptr));
    check("slot_write address", 64'(info[15:0]), 64'(slot_wr_addr));
    check("slot_write header", 64'(info[31]), 64'(slot_for_hdr));
    finish_cmd();
  endtask

  task automatic raise_dram_flags;
    core_bus_pkg::word_t rd;
    recv_dram_tag       = 5'd3;
    recv_dram_tag_valid = 1'b1;
    step_cycle();
    recv_dram_tag = 5'd0;
    step_cycle();
    recv_dram_tag_valid = 1'b0;
    step_cycle();
    step_cycle();
    bus_read(io_addr(`CIO_RD_FLAGS), rd);
    check("dram_flags tag 3 only", 64'h8, 64'(rd));
    @(negedge clk);
    check("dram_flags irq masked", 64'd0, 64'(external_irq));
    step_cycle();
    bus_write(io_addr(`CIO_MASK_WR), 32'h0000_0005, 2'd0);
    @(negedge clk);
    check("dram_flags irq unmasked", 64'd1, 64'(external_irq));
    step_cycle();
    bus_write(io_addr(`CIO_FLAG_CLR), 32'h0003_0000, 2'd0);
    bus_read(io_addr(`CIO_RD_FLAGS), rd);
    check("dram_flags cleared", 64'd0, 64'(rd));
    @(negedge clk);
    check("dram_flags irq dropped", 64'd0, 64'(external_irq));
    step_cycle();
  endtask

  task automatic run_timer_and_ack;
    int waited;
    bus_write(io_addr(`CIO_TIMER_STEP), 32'd20, 2'd2);
    bus_write(io_addr(`CIO_MASK_WR), 32'h0000_0003, 2'd0);
    waited = 1;
    @(negedge clk);
    check("timer_ack restarted by step write", 64'd0, 64'(timer_irq));
    while (!timer_irq && waited < 21) begin
      @(negedge clk);
      waited++;
    end
    if (!timer_irq) begin
      errors++;
      $display("Timer interrupt did not rise within 21 cycles of the step write");
    end
    step_cycle();
    bus_write(io_addr(`CIO_IRQ_ACK), 32'h0000_2000, 2'd0);
    @(negedge clk);
    check("timer_ack timer cleared", 64'd0, 64'(timer_irq));
    check("timer_ack no external ack", 64'd0, 64'(interrupt_in_ack));
    step_cycle();
    bus_write(io_addr(`CIO_IRQ_ACK), 32'h0000_1000, 2'd0);
    @(negedge clk);
    check("timer_ack external ack", 64'd1, 64'(interrupt_in_ack));
    step_cycle();
    @(negedge clk);
    check("timer_ack ack one cycle", 64'd0, 64'(interrupt_in_ack));
    step_cycle();
  endtask

  task automatic finish_run(input bit timed_out);
    int assert_fails;
    assert_fails = dut.u_asserts.slot_fails + dut.u_asserts.hold_fails +
                   dut.u_asserts.rsp_fails;
    $display("Closing: %0d check errors, %0d assertion failures, %0d cycles",
             errors, assert_fails, cycles);
    if (errors == 0 && assert_fails == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'hb17e_8afe));
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0203);
    end
    rst                 = 1'b1;
    init_rst            = 1'b1;
    core_id             = 4'h6;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    recv_dram_tag       = '0;
    recv_dram_tag_valid = 1'b0;
    data_desc_ready     = 1'b0;
    slot_wr_ready       = 1'b0;
    interrupt_in        = 1'b0;
    idle_cmd();
    repeat (4) @(posedge clk);
    #10;
    rst      = 1'b0;
    init_rst = 1'b0;
    step_cycle();
    route_mem_accesses();
    send_descriptor();
    read_io_registers();
    write_slot_info();
    raise_dram_flags();
    run_timer_and_ack();
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/core_bus_pkg.sv
source/core_io_pkg.sv
source/io_bus_if.sv
source/dbus_router.sv
source/io_write_regs.sv
source/io_read_regs.sv
source/irq_ctrl.sv
source/core_io_top.sv
test/core_io_asserts.sv
test/core_io_tb.sv
